//--- spmm_pkg.sv
package spmm_pkg;

  // datapath widths
  localparam int DATA_W     = 8;
  localparam int ACC_W      = 20;
  localparam int COL_IDX_W  = 5;
  localparam int NNZ_ADDR_W = 7;
  localparam int ROW_LEN_W  = 4;
  localparam int NUM_NODE_W = 4;
  localparam int ROW_ADDR_W = 5;

  // defaults for the top-level parameters
  localparam int DEF_NUM_COLS = 4;
  localparam int DEF_WH_DEPTH = 8;

  // load data holds a full W row at 32 columns
  localparam int MAX_COLS    = 32;
  localparam int LOAD_DATA_W = MAX_COLS * DATA_W;

  typedef struct packed {
    logic [ROW_LEN_W-1:0]  row_len;
    logic [NUM_NODE_W-1:0] num_nodes;
    logic                  src_flag;
  } node_info_t;

  typedef enum logic [1:0] {
    MEM_COL_IDX,
    MEM_VALUE,
    MEM_NODE_INFO,
    MEM_WEIGHT
  } mem_sel_e;

  typedef struct packed {
    logic                   we;
    mem_sel_e               sel;
    logic [NNZ_ADDR_W-1:0]  addr;
    logic [LOAD_DATA_W-1:0] data;
  } load_req_t;

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_DRAIN} ctrl_state_e;

endpackage

//--- spmm_ram.sv
module spmm_ram #(
  parameter int  DEPTH = 32,
  parameter int  WIDTH = 8,
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic             clk,
  input  logic             we_i,
  input  logic [AW-1:0]    waddr_i,
  input  logic [WIDTH-1:0] wdata_i,
  input  logic [AW-1:0]    raddr_a_i,
  input  logic [AW-1:0]    raddr_b_i,
  output logic [WIDTH-1:0] rdata_a_o,
  output logic [WIDTH-1:0] rdata_b_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // both read ports registered, old data on a same-address write
  always_ff @(posedge clk) begin
    rdata_a_o <= mem[raddr_a_i];
    rdata_b_o <= mem[raddr_b_i];
  end

endmodule

//--- node_info_fifo.sv
module node_info_fifo import spmm_pkg::*; #(
  parameter int  FIFO_DEPTH = 8,
  localparam int PTR_W      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1,
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push_i,
  input  node_info_t push_data_i,
  input  logic       pop_i,
  output node_info_t head_o,
  output logic       empty_o,
  output logic       full_o
);

  node_info_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty_o = (count == '0);
  assign full_o  = (count == CNT_W'(FIFO_DEPTH));
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // head visible without read delay
  assign head_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

endmodule

//--- sp_pe.sv
module sp_pe import spmm_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     valid_i,
  input  logic                     last_i,
  input  logic signed [DATA_W-1:0] value_i,
  input  logic signed [DATA_W-1:0] weight_i,
  output logic signed [ACC_W-1:0]  result_o,
  output logic                     done_o
);

  localparam int PROD_W = 2 * DATA_W;

  logic signed [PROD_W-1:0] prod;
  logic signed [ACC_W-1:0]  prod_ext;
  logic signed [ACC_W-1:0]  acc;
  logic signed [ACC_W-1:0]  sum;

  assign prod     = value_i * weight_i;
  assign prod_ext = {{(ACC_W - PROD_W){prod[PROD_W-1]}}, prod};
  assign sum      = acc + prod_ext;

  // acc restarts at zero after last, so rows can follow back to back
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc    <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= valid_i && last_i;
      if (valid_i) begin
        if (last_i) begin
          acc <= '0;
        end else begin
          acc <= sum;
        end
      end
    end
  end

  // row result held until the next row ends
  always_ff @(posedge clk) begin
    if (valid_i && last_i) begin
      result_o <= sum;
    end
  end

endmodule

//--- spmm_ctrl.sv
module spmm_ctrl import spmm_pkg::*; #(
  parameter int  NUM_COLS   = DEF_NUM_COLS,
  parameter int  WH_DEPTH   = DEF_WH_DEPTH,
  parameter int  FIFO_DEPTH = 8,
  localparam int WH_ADDR_W  = (WH_DEPTH > 1) ? $clog2(WH_DEPTH) : 1,
  localparam int WH_W       = NUM_COLS * ACC_W + NUM_NODE_W + 1
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start_i,
  input  logic [ROW_ADDR_W-1:0]        num_rows_i,
  input  node_info_t                   node_info_i,
  input  node_info_t                   node_info_nxt_i,
  output logic [NNZ_ADDR_W-1:0]        nnz_addr_o,
  output logic [ROW_ADDR_W-1:0]        node_addr_o,
  output logic [ROW_ADDR_W-1:0]        node_addr_nxt_o,
  input  logic signed [DATA_W-1:0]     value_i,
  input  logic [NUM_COLS*DATA_W-1:0]   weight_row_i,
  output logic                         busy_o,
  output logic                         done_o,
  output logic                         wh_we_o,
  output logic [WH_ADDR_W-1:0]         wh_addr_o,
  output logic [WH_W-1:0]              wh_data_o
);

  ctrl_state_e                state;
  logic [ROW_ADDR_W-1:0]      num_rows_q;
  logic [ROW_ADDR_W-1:0]      row_addr;
  logic [ROW_LEN_W-1:0]       nnz_cnt;
  logic                       adv_q;
  node_info_t                 cur_info;
  logic                       first_nnz;
  logic                       last_nnz;
  logic                       last_row;
  logic                       issue;
  logic                       fifo_push;
  logic                       fifo_pop;
  logic                       fifo_empty;
  logic                       fifo_full;
  node_info_t                 fifo_head;
  logic                       issue_q;
  logic                       last_q;
  logic                       pe_valid;
  logic                       pe_last;
  logic signed [DATA_W-1:0]   value_q;
  logic [NUM_COLS-1:0]        pe_done;
  logic signed [ACC_W-1:0]    result [NUM_COLS];
  logic [NUM_COLS*ACC_W-1:0]  result_cat;

  // right after a row change the main port still shows the old row
  assign cur_info  = adv_q ? node_info_nxt_i : node_info_i;
  assign first_nnz = (nnz_cnt == '0);
  assign last_nnz  = (nnz_cnt == cur_info.row_len - 1'b1);
  assign last_row  = (row_addr == num_rows_q - 1'b1);

  // hold a new row while the queue has no room for it
  assign issue     = (state == S_ISSUE) && !(first_nnz && fifo_full);
  assign fifo_push = issue && first_nnz;

  assign node_addr_o     = row_addr;
  assign node_addr_nxt_o = row_addr + 1'b1;
  assign busy_o          = (state != S_IDLE);
  assign done_o          = (state == S_DRAIN) && fifo_empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      num_rows_q <= '0;
      row_addr   <= '0;
      nnz_cnt    <= '0;
      nnz_addr_o <= '0;
      adv_q      <= 1'b0;
    end else begin
      adv_q <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start_i) begin
            state      <= S_ISSUE;
            num_rows_q <= num_rows_i;
            nnz_cnt    <= '0;
            nnz_addr_o <= '0;
          end
        end
        S_ISSUE: begin
          if (issue) begin
            nnz_addr_o <= nnz_addr_o + 1'b1;
            if (!last_nnz) begin
              nnz_cnt <= nnz_cnt + 1'b1;
            end else begin
              nnz_cnt <= '0;
              if (last_row) begin
                state <= S_DRAIN;
              end else begin
                row_addr <= row_addr + 1'b1;
                adv_q    <= 1'b1;
              end
            end
          end
        end
        S_DRAIN: begin
          // row 0 is presented again while idle
          if (fifo_empty) begin
            state    <= S_IDLE;
            row_addr <= '0;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // two cycles to meet the W row behind the column index read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      issue_q  <= 1'b0;
      last_q   <= 1'b0;
      pe_valid <= 1'b0;
      pe_last  <= 1'b0;
    end else begin
      issue_q  <= issue;
      last_q   <= issue && last_nnz;
      pe_valid <= issue_q;
      pe_last  <= last_q;
    end
  end

  always_ff @(posedge clk) begin
    value_q <= value_i;
  end

  node_info_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (fifo_push),
    .push_data_i (cur_info),
    .pop_i       (fifo_pop),
    .head_o      (fifo_head),
    .empty_o     (fifo_empty),
    .full_o      (fifo_full)
  );

  for (genvar c = 0; c < NUM_COLS; c++) begin : g_pe
    sp_pe u_pe (
      .clk      (clk),
      .rst_n    (rst_n),
      .valid_i  (pe_valid),
      .last_i   (pe_last),
      .value_i  (value_q),
      .weight_i (weight_row_i[c*DATA_W +: DATA_W]),
      .result_o (result[c]),
      .done_o   (pe_done[c])
    );
    // column 0 ends up in the top bits
    assign result_cat[(NUM_COLS-1-c)*ACC_W +: ACC_W] = result[c];
  end

  assign wh_we_o   = &pe_done;
  assign fifo_pop  = wh_we_o;
  assign wh_data_o = {result_cat, fifo_head.num_nodes, fifo_head.src_flag};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wh_addr_o <= '0;
    end else if (wh_we_o) begin
      if (wh_addr_o == WH_ADDR_W'(WH_DEPTH - 1)) begin
        wh_addr_o <= '0;
      end else begin
        wh_addr_o <= wh_addr_o + 1'b1;
      end
    end
  end

endmodule

//--- spmm_top.sv
module spmm_top import spmm_pkg::*; #(
  parameter int  NUM_COLS   = DEF_NUM_COLS,
  parameter int  WH_DEPTH   = DEF_WH_DEPTH,
  parameter int  FIFO_DEPTH = 8,
  localparam int WH_ADDR_W  = (WH_DEPTH > 1) ? $clog2(WH_DEPTH) : 1,
  localparam int WH_W       = NUM_COLS * ACC_W + NUM_NODE_W + 1
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  load_req_t             load_i,
  input  logic                  start_i,
  input  logic [ROW_ADDR_W-1:0] num_rows_i,
  output logic                  busy_o,
  output logic                  done_o,
  output logic                  wh_we_o,
  output logic [WH_ADDR_W-1:0]  wh_addr_o,
  output logic [WH_W-1:0]       wh_data_o
);

  localparam int INFO_W = $bits(node_info_t);
  localparam int ROW_W  = NUM_COLS * DATA_W;

  logic                     col_we;
  logic                     value_we;
  logic                     info_we;
  logic                     weight_we;
  logic [NNZ_ADDR_W-1:0]    nnz_addr;
  logic [ROW_ADDR_W-1:0]    node_addr;
  logic [ROW_ADDR_W-1:0]    node_addr_nxt;
  logic [COL_IDX_W-1:0]     col_idx;
  logic signed [DATA_W-1:0] value;
  node_info_t               node_info;
  node_info_t               node_info_nxt;
  logic [ROW_W-1:0]         weight_row;

  // load port decode
  assign col_we    = load_i.we && (load_i.sel == MEM_COL_IDX);
  assign value_we  = load_i.we && (load_i.sel == MEM_VALUE);
  assign info_we   = load_i.we && (load_i.sel == MEM_NODE_INFO);
  assign weight_we = load_i.we && (load_i.sel == MEM_WEIGHT);

  spmm_ram #(.DEPTH(2 ** NNZ_ADDR_W), .WIDTH(COL_IDX_W)) u_col_ram (
    .clk (clk), .we_i (col_we), .waddr_i (load_i.addr),
    .wdata_i (load_i.data[COL_IDX_W-1:0]),
    .raddr_a_i (nnz_addr), .raddr_b_i (nnz_addr),
    .rdata_a_o (col_idx), .rdata_b_o ()
  );

  spmm_ram #(.DEPTH(2 ** NNZ_ADDR_W), .WIDTH(DATA_W)) u_value_ram (
    .clk (clk), .we_i (value_we), .waddr_i (load_i.addr),
    .wdata_i (load_i.data[DATA_W-1:0]),
    .raddr_a_i (nnz_addr), .raddr_b_i (nnz_addr),
    .rdata_a_o (value), .rdata_b_o ()
  );

  // port b reads one row ahead
  spmm_ram #(.DEPTH(2 ** ROW_ADDR_W), .WIDTH(INFO_W)) u_info_ram (
    .clk (clk), .we_i (info_we), .waddr_i (load_i.addr[ROW_ADDR_W-1:0]),
    .wdata_i (load_i.data[INFO_W-1:0]),
    .raddr_a_i (node_addr), .raddr_b_i (node_addr_nxt),
    .rdata_a_o (node_info), .rdata_b_o (node_info_nxt)
  );

  // W row addressed straight from the column index output
  spmm_ram #(.DEPTH(2 ** COL_IDX_W), .WIDTH(ROW_W)) u_weight_ram (
    .clk (clk), .we_i (weight_we), .waddr_i (load_i.addr[COL_IDX_W-1:0]),
    .wdata_i (load_i.data[ROW_W-1:0]),
    .raddr_a_i (col_idx), .raddr_b_i (col_idx),
    .rdata_a_o (weight_row), .rdata_b_o ()
  );

  spmm_ctrl #(
    .NUM_COLS   (NUM_COLS),
    .WH_DEPTH   (WH_DEPTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start_i),
    .num_rows_i      (num_rows_i),
    .node_info_i     (node_info),
    .node_info_nxt_i (node_info_nxt),
    .nnz_addr_o      (nnz_addr),
    .node_addr_o     (node_addr),
    .node_addr_nxt_o (node_addr_nxt),
    .value_i         (value),
    .weight_row_i    (weight_row),
    .busy_o          (busy_o),
    .done_o          (done_o),
    .wh_we_o         (wh_we_o),
    .wh_addr_o       (wh_addr_o),
    .wh_data_o       (wh_data_o)
  );

endmodule

//--- spmm_props.sv
module spmm_props import spmm_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input ctrl_state_e state_i,
  input logic        wh_we_i,
  input logic        done_i,
  input logic        full_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // WH writes only while a run is active
  a_we_in_run: assert property (@(posedge clk) disable iff (!rst_n)
    wh_we_i |-> (state_i == S_ISSUE || state_i == S_DRAIN))
    else $error("WH write enable seen outside a run");

  // done right behind a WH write, never two cycles in a row
  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> $past(wh_we_i) && !$past(done_i))
    else $error("done_o not a single pulse right after a WH write");

  // at most 4 rows in flight, so a push never meets a full queue
  a_queue_never_full: assert property (@(posedge clk) disable iff (!rst_n)
    !full_i)
    else $error("node info queue filled up");

endmodule

bind spmm_ctrl spmm_props u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .state_i (state),
  .wh_we_i (wh_we_o),
  .done_i  (done_o),
  .full_i  (fifo_full)
);

//--- tb_spmm.sv
module tb_spmm import spmm_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_COLS  = DEF_NUM_COLS;
  localparam int WH_DEPTH  = DEF_WH_DEPTH;
  localparam int WH_ADDR_W = $clog2(WH_DEPTH);
  localparam int WH_W      = NUM_COLS * ACC_W + NUM_NODE_W + 1;
  localparam int NUM_CASES = 8;
  localparam int W_ROWS    = 2 ** COL_IDX_W;
  localparam int MAX_ROWS  = 2 ** ROW_ADDR_W;
  localparam int MAX_NNZ   = 2 ** NNZ_ADDR_W;

  typedef struct packed {
    logic [ROW_ADDR_W-1:0] num_rows;
    logic [1:0]            layout;
    logic                  reset_mid;
  } case_t;

  // layout 0 random lengths, 1 all length 1, 2 alternating 1 and 4, 3 negative values
  case_t cases [NUM_CASES] = '{
    '{5'd1,  2'd1, 1'b0},
    '{5'd6,  2'd0, 1'b0},
    '{5'd5,  2'd1, 1'b0},
    '{5'd7,  2'd2, 1'b0},
    '{5'd9,  2'd3, 1'b0},
    '{5'd31, 2'd0, 1'b0},
    '{5'd10, 2'd2, 1'b1},
    '{5'd4,  2'd3, 1'b0}
  };

  logic                  clk = 1'b0;
  logic                  rst_n;
  load_req_t             load_i;
  logic                  start_i;
  logic [ROW_ADDR_W-1:0] num_rows_i;
  logic                  busy_o;
  logic                  done_o;
  logic                  wh_we_o;
  logic [WH_ADDR_W-1:0]  wh_addr_o;
  logic [WH_W-1:0]       wh_data_o;

  int                       row_len [MAX_ROWS];
  node_info_t               info [MAX_ROWS];
  logic [COL_IDX_W-1:0]     col_idx [MAX_NNZ];
  logic signed [DATA_W-1:0] value [MAX_NNZ];
  logic signed [DATA_W-1:0] weight [W_ROWS][NUM_COLS];
  logic [WH_W-1:0]          exp_q [$];
  int                       nnz_total;
  int                       exp_addr;
  int                       errors;
  int                       checks;
  int                       run_cycles = 0;
  int                       cycle_limit = 0;
  logic                     running = 1'b0;

  spmm_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_i     (load_i),
    .start_i    (start_i),
    .num_rows_i (num_rows_i),
    .busy_o     (busy_o),
    .done_o     (done_o),
    .wh_we_o    (wh_we_o),
    .wh_addr_o  (wh_addr_o),
    .wh_data_o  (wh_data_o)
  );

  always #4 clk = ~clk;

  // only cycles spent waiting on a run count toward the limit
  always @(posedge clk) begin
    if (running) begin
      run_cycles <= run_cycles + 1;
    end
    if (run_cycles > cycle_limit) begin
      $display("Timeout: no done_o within the limit of %0d run cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic gen_case(input case_t tc);
    int k;
    k = 0;
    for (int r = 0; r < int'(tc.num_rows); r++) begin
      case (tc.layout)
        2'd1: row_len[r] = 1;
        2'd2: row_len[r] = (r % 2 == 0) ? 1 : 4;
        default: row_len[r] = $urandom_range(4, 1);
      endcase
      info[r].row_len   = ROW_LEN_W'(row_len[r]);
      info[r].num_nodes = NUM_NODE_W'($urandom);
      info[r].src_flag  = 1'($urandom);
      for (int j = 0; j < row_len[r]; j++) begin
        col_idx[k] = COL_IDX_W'($urandom);
        value[k]   = DATA_W'($urandom);
        if (tc.layout == 2'd3) begin
          value[k][DATA_W-1] = 1'b1;
        end
        k++;
      end
    end
    nnz_total = k;
    for (int w = 0; w < W_ROWS; w++) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        weight[w][c] = DATA_W'($urandom);
      end
    end
  endtask

  task automatic load_word(input mem_sel_e sel, input int addr,
                           input logic [LOAD_DATA_W-1:0] data);
    @(posedge clk);
    load_i.we   <= 1'b1;
    load_i.sel  <= sel;
    load_i.addr <= NNZ_ADDR_W'(addr);
    load_i.data <= data;
  endtask

  task automatic load_case(input int rows);
    logic [LOAD_DATA_W-1:0] d;
    for (int k = 0; k < nnz_total; k++) begin
      load_word(MEM_COL_IDX, k, LOAD_DATA_W'(col_idx[k]));
      load_word(MEM_VALUE, k, LOAD_DATA_W'(value[k]));
    end
    for (int r = 0; r < rows; r++) begin
      load_word(MEM_NODE_INFO, r, LOAD_DATA_W'(info[r]));
    end
    for (int w = 0; w < W_ROWS; w++) begin
      d = '0;
      for (int c = 0; c < NUM_COLS; c++) begin
        d[c*DATA_W +: DATA_W] = weight[w][c];
      end
      load_word(MEM_WEIGHT, w, d);
    end
    @(posedge clk);
    load_i.we <= 1'b0;
  endtask

  // CSR reference with column 0 in the top slice
  task automatic predict(input int rows);
    int              k;
    int              sum;
    logic [WH_W-1:0] word;
    k = 0;
    for (int r = 0; r < rows; r++) begin
      word = '0;
      for (int c = 0; c < NUM_COLS; c++) begin
        sum = 0;
        for (int j = 0; j < row_len[r]; j++) begin
          sum += int'(value[k + j]) * int'(weight[col_idx[k + j]][c]);
        end
        word[WH_W-1-c*ACC_W -: ACC_W] = ACC_W'(sum);
      end
      word[NUM_NODE_W:1] = info[r].num_nodes;
      word[0]            = info[r].src_flag;
      exp_q.push_back(word);
      k += row_len[r];
    end
  endtask

  task automatic pulse_start(input int rows);
    @(posedge clk);
    start_i    <= 1'b1;
    num_rows_i <= ROW_ADDR_W'(rows);
    @(posedge clk);
    start_i <= 1'b0;
  endtask

  task automatic run_case(input int rows);
    logic [WH_W-1:0] exp_word;
    int              writes;
    writes = 0;
    pulse_start(rows);
    running = 1'b1;
    do begin
      @(negedge clk);
      check("busy_o", 128'(busy_o), 128'(1));
      if (wh_we_o) begin
        writes++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Error at %0t: WH write with no row left to expect", $time);
        end else begin
          exp_word = exp_q.pop_front();
          check("wh_data_o", 128'(wh_data_o), 128'(exp_word));
          check("wh_addr_o", 128'(wh_addr_o), 128'(exp_addr % WH_DEPTH));
          exp_addr++;
        end
      end
    end while (!done_o);
    running = 1'b0;
    check("wh_write_count", 128'(writes), 128'(rows));
    exp_q.delete();
  endtask

  // abandon a run partway so the WH address starts over
  task automatic reset_mid_run(input int rows);
    pulse_start(rows);
    // reset lands on the cycle of the second row's WH write
    repeat (6) @(posedge clk);
    rst_n <= 1'b0;
    repeat (2) @(negedge clk);
    check("busy_o", 128'(busy_o), 128'(0));
    check("wh_we_o", 128'(wh_we_o), 128'(0));
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    exp_addr = 0;
    repeat (2) @(posedge clk);
  endtask

  initial begin
    int rows;
    int case_errors;
    void'($urandom(10));
    rst_n      = 1'b0;
    start_i    = 1'b0;
    num_rows_i = '0;
    load_i     = '0;
    exp_addr   = 0;
    errors     = 0;
    checks     = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < NUM_CASES; i++) begin
      case_errors = errors;
      rows        = int'(cases[i].num_rows);
      gen_case(cases[i]);
      cycle_limit += nnz_total + 20;
      load_case(rows);
      predict(rows);
      repeat (2) @(posedge clk);
      if (cases[i].reset_mid) begin
        reset_mid_run(rows);
      end
      run_case(rows);
      $display("case %0d: %0d rows, %0d nonzeros, %0d errors",
               i, rows, nnz_total, errors - case_errors);
      repeat (2) @(posedge clk);
    end
    $display("summary: %0d cases, %0d checks, %0d errors", NUM_CASES, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
spmm_pkg.sv
spmm_ram.sv
node_info_fifo.sv
sp_pe.sv
spmm_ctrl.sv
spmm_top.sv
spmm_props.sv
tb_spmm.sv

//--- run.sh
#!/bin/sh
# build and run the spmm testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f sim.f --top-module tb_spmm --Mdir obj_dir -o tb_spmm
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_spmm)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
